/* hw/hps_cfg_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, types and command codes of the host
// config path. Everything runs on a single clock
//////////////////////////////////////////////////
package hps_cfg_pkg;

	// Field widths
	localparam int WORD_W   = 16;
	localparam int DIM_W    = 12;
	localparam int RATIO_W  = 8;
	localparam int SAMPLE_W = 16;
	localparam int ATT_W    = 5;
	localparam int MIX_W    = 2;

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [DIM_W-1:0]    dim_t;
	typedef logic [RATIO_W-1:0]  ratio_t;
	typedef logic [SAMPLE_W-1:0] sample_t;
	// Bit 4 mutes, bits 3:0 are a right shift
	typedef logic [ATT_W-1:0]    att_t;
	typedef logic [MIX_W-1:0]    mix_t;
	typedef logic [7:0]          cmd_t;

	//////////////////////////////////////////////////
	// Host commands, low byte of the first word
	//////////////////////////////////////////////////
	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_VOLUME = 8'h26;
	localparam cmd_t CMD_VSET   = 8'h27;
	localparam cmd_t CMD_ASPECT = 8'h2C;
	localparam cmd_t CMD_FBWIN  = 8'h2F;

	// 1920x1080 until the host sends timing
	localparam int WIDTH_RESET  = 1920;
	localparam int HEIGHT_RESET = 1080;

	// Window calculator, one pass is eight states
	typedef enum logic [2:0] {
		IDLE,
		CALC,
		WAIT_0,
		WAIT_1,
		WAIT_2,
		WAIT_3,
		CLIP,
		PLACE
	} WIN_STATE_T;

endpackage

/* hw/video_cfg_if.sv */
//////////////////////////////////////////////////
// Static video settings, no handshake. Sink reads
// the registered values continuously
//////////////////////////////////////////////////
interface video_cfg_if;

	hps_cfg_pkg::dim_t   width;
	hps_cfg_pkg::dim_t   height;
	hps_cfg_pkg::dim_t   vset;
	hps_cfg_pkg::ratio_t arx;
	hps_cfg_pkg::ratio_t ary;
	logic                fb_en;
	hps_cfg_pkg::dim_t   fb_hmin;
	hps_cfg_pkg::dim_t   fb_hmax;
	hps_cfg_pkg::dim_t   fb_vmin;
	hps_cfg_pkg::dim_t   fb_vmax;

	modport source (
		output width, height, vset, arx, ary,
		output fb_en, fb_hmin, fb_hmax, fb_vmin, fb_vmax
	);

	modport sink (
		input width, height, vset, arx, ary,
		input fb_en, fb_hmin, fb_hmax, fb_vmin, fb_vmax
	);

endinterface

/* hw/hps_cmd_decoder.sv */
//////////////////////////////////////////////////
// Host word link and command decoding. The host
// paces the link, the decoder never stalls
//////////////////////////////////////////////////
module hps_cmd_decoder #(
	parameter int DEFAULT_WIDTH  = 1920,
	parameter int DEFAULT_HEIGHT = 1080
) (
	input  logic               clk,
	input  logic               resetd,
	input  logic               i_io_sel,
	input  logic               i_io_clk,
	input  hps_cfg_pkg::word_t i_io_din,
	output logic               o_io_ack,
	output hps_cfg_pkg::att_t  o_att,
	video_cfg_if.source        cfg
);

	logic              rack;
	logic              strobe;
	logic              has_cmd;
	hps_cfg_pkg::cmd_t cmd;
	logic [3:0]        cnt;

	// First cycle with io_clk high after low
	assign strobe = i_io_clk & ~rack;

	// Ack is io_clk delayed by two flops
	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	//////////////////////////////////////////////////
	// Command and data words
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd    <= 1'b0;
			cmd        <= '0;
			cnt        <= '0;
			o_att      <= '0;
			cfg.width  <= hps_cfg_pkg::dim_t'(DEFAULT_WIDTH);
			cfg.height <= hps_cfg_pkg::dim_t'(DEFAULT_HEIGHT);
			cfg.vset   <= '0;
			cfg.arx    <= '0;
			cfg.ary    <= '0;
			cfg.fb_en  <= 1'b0;
		end else if (!i_io_sel) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_io_din[7:0];
				cnt     <= '0;
			end else begin
				// Data word index saturates, later words are don't care
				if (cnt != 4'hf) cnt <= cnt + 4'd1;
				case (cmd)
					hps_cfg_pkg::CMD_TIMING: begin
						// Porch and sync words are skipped
						if (cnt == 4'd0) cfg.width <= i_io_din[11:0];
						if (cnt == 4'd4) cfg.height <= i_io_din[11:0];
					end
					hps_cfg_pkg::CMD_VOLUME: begin
						if (cnt == 4'd0) o_att <= i_io_din[4:0];
					end
					hps_cfg_pkg::CMD_VSET: begin
						if (cnt == 4'd0) cfg.vset <= i_io_din[11:0];
					end
					hps_cfg_pkg::CMD_ASPECT: begin
						if (cnt == 4'd0) begin
							cfg.arx <= i_io_din[15:8];
							cfg.ary <= i_io_din[7:0];
						end
					end
					hps_cfg_pkg::CMD_FBWIN: begin
						case (cnt)
							4'd0: cfg.fb_en <= i_io_din[15];
							4'd5: cfg.fb_hmin <= i_io_din[11:0];
							4'd6: cfg.fb_hmax <= i_io_din[11:0];
							4'd7: cfg.fb_vmin <= i_io_din[11:0];
							4'd8: cfg.fb_vmax <= i_io_din[11:0];
							default: begin
							end
						endcase
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Ack only moves when io_clk moved two cycles before
	a_ack_follows_clk: assert property (@(posedge clk) disable iff (resetd)
		(o_io_ack != $past(o_io_ack)) |-> ($past(i_io_clk, 2) != $past(o_io_ack, 2)));

endmodule

/* hw/video_window.sv */
//////////////////////////////////////////////////
// Active picture window. Dividers are combinational
// and read only after the wait states
//////////////////////////////////////////////////
module video_window (
	input  logic              clk,
	input  logic              resetd,
	video_cfg_if.sink         cfg,
	output hps_cfg_pkg::dim_t o_hmin,
	output hps_cfg_pkg::dim_t o_hmax,
	output hps_cfg_pkg::dim_t o_vmin,
	output hps_cfg_pkg::dim_t o_vmax
);

	localparam int PROD_W = hps_cfg_pkg::DIM_W + hps_cfg_pkg::RATIO_W;

	hps_cfg_pkg::WIN_STATE_T state;
	hps_cfg_pkg::dim_t       w_r, h_r, v_r;
	hps_cfg_pkg::ratio_t     arx_r, ary_r;
	hps_cfg_pkg::dim_t       videow, videoh;
	hps_cfg_pkg::dim_t       gap_w, gap_h;
	logic [PROD_W-1:0]       wcalc, hcalc;
	logic                    aspect;
	logic                    chk_q;

	assign aspect = (cfg.arx != '0) && (cfg.ary != '0);

	// Multicycle through the wait states
	assign wcalc = ((v_r != '0) ? v_r : h_r) * arx_r / ary_r;
	assign hcalc = w_r * ary_r / arx_r;

	assign gap_w = w_r - videow;
	assign gap_h = h_r - videoh;

	always_ff @(posedge clk) begin
		if (resetd) begin
			state  <= hps_cfg_pkg::IDLE;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
			chk_q  <= 1'b0;
		end else begin
			case (state)
				hps_cfg_pkg::IDLE: begin
					if (cfg.fb_en) begin
						o_hmin <= cfg.fb_hmin;
						o_hmax <= cfg.fb_hmax;
						o_vmin <= cfg.fb_vmin;
						o_vmax <= cfg.fb_vmax;
						chk_q  <= 1'b0;
					end else if (aspect) begin
						state <= hps_cfg_pkg::CALC;
					end else begin
						// Full picture
						o_hmin <= '0;
						o_hmax <= cfg.width - 12'd1;
						o_vmin <= '0;
						o_vmax <= cfg.height - 12'd1;
						chk_q  <= 1'b1;
					end
				end
				hps_cfg_pkg::CALC: begin
					// Snapshot so one pass sees one setting
					w_r   <= cfg.width;
					h_r   <= cfg.height;
					v_r   <= cfg.vset;
					arx_r <= cfg.arx;
					ary_r <= cfg.ary;
					state <= hps_cfg_pkg::WAIT_0;
				end
				hps_cfg_pkg::WAIT_0: state <= hps_cfg_pkg::WAIT_1;
				hps_cfg_pkg::WAIT_1: state <= hps_cfg_pkg::WAIT_2;
				hps_cfg_pkg::WAIT_2: state <= hps_cfg_pkg::WAIT_3;
				hps_cfg_pkg::WAIT_3: state <= hps_cfg_pkg::CLIP;
				hps_cfg_pkg::CLIP: begin
					videow <= ((v_r == '0) && (wcalc > PROD_W'(w_r))) ? w_r : wcalc[11:0];
					if (v_r != '0) videoh <= v_r;
					else videoh <= (hcalc > PROD_W'(h_r)) ? h_r : hcalc[11:0];
					state <= hps_cfg_pkg::PLACE;
				end
				default: begin
					// Centre the picture
					o_hmin <= gap_w >> 1;
					o_hmax <= (gap_w >> 1) + videow - 12'd1;
					o_vmin <= gap_h >> 1;
					o_vmax <= (gap_h >> 1) + videoh - 12'd1;
					chk_q  <= 1'b1;
					state  <= hps_cfg_pkg::IDLE;
				end
			endcase
		end
	end

	// Aspect and full windows are never inverted
	a_window_order: assert property (@(posedge clk) disable iff (resetd)
		chk_q |-> (o_hmax >= o_hmin) && (o_vmax >= o_vmin));

endmodule

/* hw/audio_mix_channel.sv */
//////////////////////////////////////////////////
// One mixer channel. Core sample must hold still
// before use, four stages follow the deglitch
//////////////////////////////////////////////////
module audio_mix_channel (
	input  logic                 clk,
	input  logic                 resetd,
	input  hps_cfg_pkg::sample_t i_core,
	input  hps_cfg_pkg::sample_t i_host,
	input  logic                 i_is_signed,
	input  hps_cfg_pkg::mix_t    i_mix,
	input  hps_cfg_pkg::att_t    i_att,
	input  hps_cfg_pkg::sample_t i_pre,
	output hps_cfg_pkg::sample_t o_pre,
	output hps_cfg_pkg::sample_t o_out
);

	hps_cfg_pkg::sample_t d1, d2, d3;
	hps_cfg_pkg::sample_t ca;
	logic signed [16:0]   a1, a2;
	logic signed [17:0]   a3;
	logic signed [17:0]   a2x, pre_x;
	logic signed [17:0]   xf;
	logic signed [17:0]   shifted;
	hps_cfg_pkg::sample_t clamped;

	// One bit of headroom so crossfeed cannot wrap
	assign a2x   = 18'(a2);
	assign pre_x = 18'($signed(i_pre));

	//////////////////////////////////////////////////
	// Crossfeed from the other channel
	//////////////////////////////////////////////////
	always_comb begin
		case (i_mix)
			2'd0: xf = a2x;
			2'd1: xf = a2x - (a2x >>> 3) + (pre_x >>> 2);
			2'd2: xf = a2x - (a2x >>> 2) + (pre_x >>> 1);
			default: xf = (a2x >>> 1) + pre_x;
		endcase
	end

	assign shifted = i_att[4] ? 18'sd0 : (a3 >>> i_att[3:0]);

	// Saturate to 16 bit signed
	always_comb begin
		if (shifted > 18'sd32767) clamped = 16'h7fff;
		else if (shifted < -18'sd32768) clamped = 16'h8000;
		else clamped = shifted[15:0];
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1    <= '0;
			d2    <= '0;
			d3    <= '0;
			ca    <= '0;
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			// Glitch filter
			if (d2 == d3) ca <= d2;

			// Unsigned input loses one bit to fit
			a1 <= i_is_signed ? $signed({ca[15], ca}) : $signed({2'b00, ca[15:1]});
			a2 <= a1 + $signed({i_host[15], i_host});
			o_pre <= a2[16:1];
			a3    <= xf;
			o_out <= clamped;
		end
	end

	// Sign survives shift and clamp, no wrap to the other limit
	a_out_in_range: assert property (@(posedge clk) disable iff (resetd)
		o_out[15] == ($past(a3[17]) && !$past(i_att[4])));

endmodule

/* hw/hps_cfg_top.sv */
//////////////////////////////////////////////////
// Host config path top. Single clock, window and
// audio settle within 16 cycles of a change
//////////////////////////////////////////////////
module hps_cfg_top #(
	parameter int DEFAULT_WIDTH  = hps_cfg_pkg::WIDTH_RESET,
	parameter int DEFAULT_HEIGHT = hps_cfg_pkg::HEIGHT_RESET
) (
	input  logic                 clk,
	input  logic                 resetd,
	input  logic                 i_io_sel,
	input  logic                 i_io_clk,
	input  hps_cfg_pkg::word_t   i_io_din,
	output logic                 o_io_ack,
	input  hps_cfg_pkg::sample_t i_audio_core_l,
	input  hps_cfg_pkg::sample_t i_audio_core_r,
	input  hps_cfg_pkg::sample_t i_audio_host_l,
	input  hps_cfg_pkg::sample_t i_audio_host_r,
	input  logic                 i_audio_signed,
	input  hps_cfg_pkg::mix_t    i_audio_mix,
	output hps_cfg_pkg::sample_t o_audio_l,
	output hps_cfg_pkg::sample_t o_audio_r,
	output hps_cfg_pkg::dim_t    o_hmin,
	output hps_cfg_pkg::dim_t    o_hmax,
	output hps_cfg_pkg::dim_t    o_vmin,
	output hps_cfg_pkg::dim_t    o_vmax
);

	video_cfg_if cfg_bus ();

	hps_cfg_pkg::att_t    att;
	hps_cfg_pkg::sample_t pre_l, pre_r;

	hps_cmd_decoder #(
		.DEFAULT_WIDTH  (DEFAULT_WIDTH),
		.DEFAULT_HEIGHT (DEFAULT_HEIGHT)
	) decoder_i (
		.clk      (clk),
		.resetd   (resetd),
		.i_io_sel (i_io_sel),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.o_att    (att),
		.cfg      (cfg_bus.source)
	);

	video_window window_i (
		.clk    (clk),
		.resetd (resetd),
		.cfg    (cfg_bus.sink),
		.o_hmin (o_hmin),
		.o_hmax (o_hmax),
		.o_vmin (o_vmin),
		.o_vmax (o_vmax)
	);

	//////////////////////////////////////////////////
	// Audio mixer with pre values crossed between channels
	//////////////////////////////////////////////////
	audio_mix_channel mix_l_i (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_audio_core_l),
		.i_host      (i_audio_host_l),
		.i_is_signed (i_audio_signed),
		.i_mix       (i_audio_mix),
		.i_att       (att),
		.i_pre       (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_channel mix_r_i (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_audio_core_r),
		.i_host      (i_audio_host_r),
		.i_is_signed (i_audio_signed),
		.i_mix       (i_audio_mix),
		.i_att       (att),
		.i_pre       (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

endmodule

/* testbench/tb_hps_cfg.sv */
//////////////////////////////////////////////////
// Testbench for the host config path. Run it from
// the project root, where the stim file path starts
//////////////////////////////////////////////////
module tb_hps_cfg;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int    RESET_CYCLES    = 10;
	localparam int    SETTLE_CYCLES   = 16;
	localparam int    ACK_LIMIT       = 8;
	localparam int    CYCLES_PER_LINE = 200;
	localparam string STIM_FILE       = "testbench/hps_cfg_stim.txt";

	logic                 clk = 1'b0;
	logic                 resetd;
	logic                 i_io_sel;
	logic                 i_io_clk;
	hps_cfg_pkg::word_t   i_io_din;
	logic                 o_io_ack;
	hps_cfg_pkg::sample_t i_audio_core_l;
	hps_cfg_pkg::sample_t i_audio_core_r;
	hps_cfg_pkg::sample_t i_audio_host_l;
	hps_cfg_pkg::sample_t i_audio_host_r;
	logic                 i_audio_signed;
	hps_cfg_pkg::mix_t    i_audio_mix;
	hps_cfg_pkg::sample_t o_audio_l;
	hps_cfg_pkg::sample_t o_audio_r;
	hps_cfg_pkg::dim_t    o_hmin;
	hps_cfg_pkg::dim_t    o_hmax;
	hps_cfg_pkg::dim_t    o_vmin;
	hps_cfg_pkg::dim_t    o_vmax;

	string ops[$];
	int    n_ops = 0;
	logic  words_sent;

	hps_cfg_top #(
		.DEFAULT_WIDTH  (1920),
		.DEFAULT_HEIGHT (1080)
	) dut_i (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_sel       (i_io_sel),
		.i_io_clk       (i_io_clk),
		.i_io_din       (i_io_din),
		.o_io_ack       (o_io_ack),
		.i_audio_core_l (i_audio_core_l),
		.i_audio_core_r (i_audio_core_r),
		.i_audio_host_l (i_audio_host_l),
		.i_audio_host_r (i_audio_host_r),
		.i_audio_signed (i_audio_signed),
		.i_audio_mix    (i_audio_mix),
		.o_audio_l      (o_audio_l),
		.o_audio_r      (o_audio_r),
		.o_hmin         (o_hmin),
		.o_hmax         (o_hmax),
		.o_vmin         (o_vmin),
		.o_vmax         (o_vmax)
	);

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_sample(input string name, input hps_cfg_pkg::sample_t got,
			input hps_cfg_pkg::sample_t exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_dim(input string name, input hps_cfg_pkg::dim_t got,
			input hps_cfg_pkg::dim_t exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Ack must stay idle until the host strobes its first word
	always @(negedge clk) begin
		if (!resetd && !words_sent && o_io_ack !== 1'b0)
			report_error("o_io_ack went high before any host word was sent");
	end

	initial begin : watchdog
		wait (n_ops > 0);
		repeat (RESET_CYCLES + CYCLES_PER_LINE * n_ops) @(posedge clk);
		$display("Watchdog expired before all stim lines were done");
		abort_run();
	end

	//////////////////////////////////////////////////
	// Host link with the full four phase handshake
	//////////////////////////////////////////////////
	task automatic send_word(input logic sel, input hps_cfg_pkg::word_t word);
		int waited;
		@(negedge clk);
		if (o_io_ack !== 1'b0)
			report_error("o_io_ack still high when a new word was due");
		@(posedge clk);
		i_io_sel   <= sel;
		i_io_din   <= word;
		i_io_clk   <= 1'b1;
		words_sent <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (o_io_ack !== 1'b1) begin
			waited++;
			if (waited > ACK_LIMIT)
				report_error("o_io_ack did not rise within 8 cycles of i_io_clk");
			@(negedge clk);
		end
		@(posedge clk);
		i_io_clk <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (o_io_ack !== 1'b0) begin
			waited++;
			if (waited > ACK_LIMIT)
				report_error("o_io_ack did not fall within 8 cycles of i_io_clk");
			@(negedge clk);
		end
	endtask

	task automatic deselect();
		@(posedge clk);
		i_io_sel <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic load_stim();
		int    fd;
		int    r;
		string line;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			report_error("cannot open the stim file");
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r > 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n")
				ops.push_back(line);
		end
		$fclose(fd);
		if (ops.size() == 0)
			report_error("stim file holds no operations");
		n_ops = ops.size();
	endtask

	task automatic run_line(input string line);
		byte                  kind;
		int                   n, sel, sgn, mix;
		int                   hmin, hmax, vmin, vmax;
		hps_cfg_pkg::word_t   word;
		hps_cfg_pkg::sample_t cl, cr, hl, hr, el, er;
		kind = line[0];
		case (kind)
			"W": begin
				n = $sscanf(line, "W %d %h", sel, word);
				if (n != 2)
					report_error({"malformed host word line: ", line});
				send_word(sel[0], word);
			end
			"D": deselect();
			"A": begin
				n = $sscanf(line, "A %h %h %h %h %d %d %h %h", cl, cr, hl, hr, sgn, mix, el, er);
				if (n != 8)
					report_error({"malformed audio line: ", line});
				@(posedge clk);
				i_audio_core_l <= cl;
				i_audio_core_r <= cr;
				i_audio_host_l <= hl;
				i_audio_host_r <= hr;
				i_audio_signed <= sgn[0];
				i_audio_mix    <= hps_cfg_pkg::mix_t'(mix);
				repeat (SETTLE_CYCLES) @(posedge clk);
				@(negedge clk);
				check_sample("o_audio_l", o_audio_l, el);
				check_sample("o_audio_r", o_audio_r, er);
			end
			"V": begin
				n = $sscanf(line, "V %d %d %d %d", hmin, hmax, vmin, vmax);
				if (n != 4)
					report_error({"malformed window line: ", line});
				repeat (SETTLE_CYCLES) @(posedge clk);
				@(negedge clk);
				check_dim("o_hmin", o_hmin, hps_cfg_pkg::dim_t'(hmin));
				check_dim("o_hmax", o_hmax, hps_cfg_pkg::dim_t'(hmax));
				check_dim("o_vmin", o_vmin, hps_cfg_pkg::dim_t'(vmin));
				check_dim("o_vmax", o_vmax, hps_cfg_pkg::dim_t'(vmax));
			end
			default: report_error({"unknown stim line: ", line});
		endcase
	endtask

	initial begin
		resetd         = 1'b1;
		i_io_sel       = 1'b0;
		i_io_clk       = 1'b0;
		i_io_din       = '0;
		i_audio_core_l = '0;
		i_audio_core_r = '0;
		i_audio_host_l = '0;
		i_audio_host_r = '0;
		i_audio_signed = 1'b1;
		i_audio_mix    = '0;
		words_sent     = 1'b0;
		load_stim();
		repeat (RESET_CYCLES) @(posedge clk);
		resetd <= 1'b0;
		foreach (ops[i])
			run_line(ops[i]);
		$display("Test passed");
		$finish;
	end

endmodule

/* testbench/hps_cfg_stim.txt */
# W sel word         host word (hex) with full handshake; D drops select
# A core_l core_r host_l host_r signed mix exp_l exp_r (hex); V hmin hmax vmin vmax (decimal)
V 0 1919 0 1079
# Timing 1600x1200, porch words ignored
W 1 0020
W 1 0640
W 1 0011
W 1 0022
W 1 0033
W 1 04b0
W 1 0044
D
V 0 1599 0 1199
# Aspect 16:9
W 1 002c
W 1 1009
D
V 0 1599 150 1049
# Fixed vertical size 600
W 1 0027
W 1 0258
D
V 267 1332 300 899
# Framebuffer window cut short, then sent again
W 1 002f
W 1 8000
W 1 0000
D
W 1 002f
W 1 8000
W 1 0000
W 1 0000
W 1 0000
W 1 0000
W 1 0010
W 1 0020
W 1 0030
W 1 0040
D
V 16 32 48 64
W 1 002f
W 1 0000
D
V 267 1332 300 899
# Mixer, signed then unsigned
A 1000 f000 0100 0200 1 0 1100 f200
A 7000 9000 7000 9000 1 0 7fff 8000
A 0800 0400 0000 0000 1 1 0780 0480
A 0800 fc00 0000 0000 1 2 0500 ff00
A 0003 fffb 0000 0000 1 3 fffe fffe
A 8000 8000 8000 8000 1 3 8000 8000
A 8000 0000 0000 c000 0 0 4000 c000
A ffff 2000 1000 0000 0 1 7fff 1fff
A 1000 3000 0000 0000 0 2 0c00 1400
# Attenuation: shift 3, shift 15, mute, shift 0
W 1 0026
W 1 0003
D
A 1000 f000 0100 0200 1 0 0220 fe40
W 1 0026
W 1 000f
D
A 1000 f000 0100 0200 1 0 0000 ffff
W 1 0026
W 1 0010
D
A 1000 f000 0100 0200 1 0 0000 0000
W 1 0026
W 1 0000
D
A 1000 f000 0100 0200 1 0 1100 f200

/* hps_cfg.f */
hw/hps_cfg_pkg.sv
hw/video_cfg_if.sv
hw/hps_cmd_decoder.sv
hw/video_window.sv
hw/audio_mix_channel.sv
hw/hps_cfg_top.sv
testbench/tb_hps_cfg.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_hps_cfg
FILELIST  ?= hps_cfg.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
